// ==== source/board_pkg.sv ====
// ===============================================
// board_pkg: shared bus structs, register map and
// default widths for the board-level peripheral SoC
// ===============================================

package board_pkg;

  // request from the external bus master
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } reg_req_t;

  // response, one cycle after the request
  typedef struct packed {
    logic        valid;
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

  // decoded request to one slave
  typedef struct packed {
    logic        sel;
    logic        write;
    logic [3:0]  offset;
    logic [31:0] wdata;
  } slv_req_t;

  localparam logic [7:0] GPIO_OUT_ADDR     = 8'h00;
  localparam logic [7:0] GPIO_DIR_ADDR     = 8'h04;
  localparam logic [7:0] GPIO_IN_ADDR      = 8'h08;
  localparam logic [7:0] GPIO_INTR_ADDR    = 8'h0C;
  localparam logic [7:0] GPIO_INTR_EN_ADDR = 8'h10;
  localparam logic [7:0] EXIT_ADDR         = 8'h20;
  localparam logic [7:0] SCRATCH_ADDR      = 8'h24;

  localparam int GPIO_WIDTH_DEF = 20;
  localparam int LED_COUNT_DEF  = 27;

  // 32-byte windows, selected by the top three address bits
  function automatic logic [2:0] win_idx(logic [7:0] addr);
    return addr[7:5];
  endfunction

  // word index inside a window
  function automatic logic [3:0] word_idx(logic [7:0] addr);
    return {1'b0, addr[4:2]};
  endfunction

endpackage

// ==== source/board_status.sv ====
// ===============================================
// board_status: reset synchronizer, reset LED and
// heartbeat counter for the clock LED
// ===============================================
`timescale 1ns/100ps

module board_status #(
  parameter int CLK_LED_COUNT_LENGTH = board_pkg::LED_COUNT_DEF
) (
  input  logic clk_gen,
  input  logic rst_n,
  output logic rst_sync_n_o,
  output logic rst_led_o,
  output logic clk_led_o
);

  logic                            rst_meta_q;
  logic                            rst_sync_q;
  logic [CLK_LED_COUNT_LENGTH-1:0] clk_count_q;

  // assert async, release after two edges
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      rst_meta_q <= 1'b0;
      rst_sync_q <= 1'b0;
    end else begin
      rst_meta_q <= 1'b1;
      rst_sync_q <= rst_meta_q;
    end
  end

  assign rst_sync_n_o = rst_sync_q;
  assign rst_led_o    = rst_sync_q;

  // free-running heartbeat
  always_ff @(posedge clk_gen or negedge rst_sync_q) begin
    if (!rst_sync_q) begin
      clk_count_q <= '0;
    end else begin
      clk_count_q <= clk_count_q + 1'b1;
    end
  end

  assign clk_led_o = clk_count_q[CLK_LED_COUNT_LENGTH-1];

  clk_led_known_a : assert property (
    @(posedge clk_gen) disable iff (!rst_sync_q)
    !$isunknown(clk_led_o)
  ) else $error("clk_led_o unknown after reset release");

endmodule

// ==== source/reg_decoder.sv ====
// ===============================================
// reg_decoder: address decode to the slave selects,
// read mux and registered response with error flag
// ===============================================
`timescale 1ns/100ps

module reg_decoder (
  input  logic                clk_gen,
  input  logic                rst_sync_n_i,
  input  board_pkg::reg_req_t reg_req_i,
  output board_pkg::reg_rsp_t reg_rsp_o,
  output board_pkg::slv_req_t gpio_req_o,
  output board_pkg::slv_req_t exit_req_o,
  input  logic [31:0]         gpio_rdata_i,
  input  logic                gpio_hit_i,
  input  logic [31:0]         exit_rdata_i,
  input  logic                exit_hit_i
);

  import board_pkg::*;

  localparam logic [2:0] GPIO_WIN = win_idx(GPIO_OUT_ADDR);
  localparam logic [2:0] EXIT_WIN = win_idx(EXIT_ADDR);

  logic        gpio_win;
  logic        exit_win;
  logic        slv_hit;
  logic [31:0] slv_rdata;
  logic        rsp_valid_q;
  logic        rsp_error_q;
  logic [31:0] rsp_rdata_q;

  assign gpio_win = (win_idx(reg_req_i.addr) == GPIO_WIN);
  assign exit_win = (win_idx(reg_req_i.addr) == EXIT_WIN);

  assign gpio_req_o = '{sel:    reg_req_i.valid & gpio_win,
                        write:  reg_req_i.write,
                        offset: word_idx(reg_req_i.addr),
                        wdata:  reg_req_i.wdata};

  assign exit_req_o = '{sel:    reg_req_i.valid & exit_win,
                        write:  reg_req_i.write,
                        offset: word_idx(reg_req_i.addr),
                        wdata:  reg_req_i.wdata};

  // no window leaves slv_hit low, which flags the error
  always_comb begin
    slv_hit   = 1'b0;
    slv_rdata = '0;
    if (gpio_win) begin
      slv_hit   = gpio_hit_i;
      slv_rdata = gpio_rdata_i;
    end else if (exit_win) begin
      slv_hit   = exit_hit_i;
      slv_rdata = exit_rdata_i;
    end
  end

  always_ff @(posedge clk_gen or negedge rst_sync_n_i) begin
    if (!rst_sync_n_i) begin
      rsp_valid_q <= 1'b0;
      rsp_error_q <= 1'b0;
    end else begin
      rsp_valid_q <= reg_req_i.valid;
      rsp_error_q <= reg_req_i.valid & ~slv_hit;
    end
  end

  // writes and unmapped accesses return zero
  always_ff @(posedge clk_gen) begin
    rsp_rdata_q <= (reg_req_i.valid && !reg_req_i.write && slv_hit) ? slv_rdata : '0;
  end

  assign reg_rsp_o = '{valid: rsp_valid_q, error: rsp_error_q, rdata: rsp_rdata_q};

  // only one request outstanding at a time
  req_spacing_a : assert property (
    @(posedge clk_gen) disable iff (!rst_sync_n_i)
    reg_req_i.valid |=> !reg_req_i.valid
  ) else $error("new request in the cycle of the previous response");

  one_select_a : assert property (
    @(posedge clk_gen) disable iff (!rst_sync_n_i)
    !(gpio_req_o.sel && exit_req_o.sel)
  ) else $error("both slave selects high");

endmodule

// ==== source/gpio_ctrl.sv ====
// ===============================================
// gpio_ctrl: output, direction, synchronized input
// and rising-edge interrupt registers
// ===============================================
`timescale 1ns/100ps

module gpio_ctrl #(
  parameter int GPIO_WIDTH = board_pkg::GPIO_WIDTH_DEF
) (
  input  logic                  clk_gen,
  input  logic                  rst_sync_n_i,
  input  board_pkg::slv_req_t   req_i,
  output logic [31:0]           rdata_o,
  output logic                  hit_o,
  input  logic [GPIO_WIDTH-1:0] gpio_i,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic [GPIO_WIDTH-1:0] gpio_oe_o,
  output logic                  intr_o
);

  import board_pkg::*;

  localparam logic [3:0] OFF_OUT     = word_idx(GPIO_OUT_ADDR);
  localparam logic [3:0] OFF_DIR     = word_idx(GPIO_DIR_ADDR);
  localparam logic [3:0] OFF_IN      = word_idx(GPIO_IN_ADDR);
  localparam logic [3:0] OFF_INTR    = word_idx(GPIO_INTR_ADDR);
  localparam logic [3:0] OFF_INTR_EN = word_idx(GPIO_INTR_EN_ADDR);

  logic [GPIO_WIDTH-1:0] out_q;
  logic [GPIO_WIDTH-1:0] dir_q;
  logic [GPIO_WIDTH-1:0] intr_q;
  logic [GPIO_WIDTH-1:0] intr_en_q;
  logic [GPIO_WIDTH-1:0] in_meta_q;
  logic [GPIO_WIDTH-1:0] in_sync_q;
  logic [GPIO_WIDTH-1:0] in_prev_q;
  logic [GPIO_WIDTH-1:0] rise;
  logic [GPIO_WIDTH-1:0] intr_clr;
  logic                  wr_en;

  assign hit_o = req_i.offset inside {OFF_OUT, OFF_DIR, OFF_IN, OFF_INTR, OFF_INTR_EN};
  assign wr_en = req_i.sel & req_i.write & hit_o;

  // two-flop input sync, third flop for edge detect
  always_ff @(posedge clk_gen or negedge rst_sync_n_i) begin
    if (!rst_sync_n_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
      in_prev_q <= '0;
    end else begin
      in_meta_q <= gpio_i;
      in_sync_q <= in_meta_q;
      in_prev_q <= in_sync_q;
    end
  end

  assign rise     = in_sync_q & ~in_prev_q;
  assign intr_clr = (wr_en && req_i.offset == OFF_INTR) ? req_i.wdata[GPIO_WIDTH-1:0] : '0;

  always_ff @(posedge clk_gen or negedge rst_sync_n_i) begin
    if (!rst_sync_n_i) begin
      out_q     <= '0;
      dir_q     <= '0;
      intr_en_q <= '0;
    end else if (wr_en) begin
      case (req_i.offset)
        OFF_OUT:     out_q     <= req_i.wdata[GPIO_WIDTH-1:0];
        OFF_DIR:     dir_q     <= req_i.wdata[GPIO_WIDTH-1:0];
        OFF_INTR_EN: intr_en_q <= req_i.wdata[GPIO_WIDTH-1:0];
        default: ;
      endcase
    end
  end

  // set wins over write-one-to-clear
  always_ff @(posedge clk_gen or negedge rst_sync_n_i) begin
    if (!rst_sync_n_i) begin
      intr_q <= '0;
    end else begin
      intr_q <= (intr_q & ~intr_clr) | rise;
    end
  end

  always_comb begin
    case (req_i.offset)
      OFF_OUT:     rdata_o = 32'(out_q);
      OFF_DIR:     rdata_o = 32'(dir_q);
      OFF_IN:      rdata_o = 32'(in_sync_q);
      OFF_INTR:    rdata_o = 32'(intr_q);
      OFF_INTR_EN: rdata_o = 32'(intr_en_q);
      default:     rdata_o = '0;
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = dir_q;
  assign intr_o    = |(intr_q & intr_en_q);

  intr_needs_edge_a : assert property (
    @(posedge clk_gen) disable iff (!rst_sync_n_i)
    (intr_q & ~$past(intr_q) & ~$past(rise)) == '0
  ) else $error("interrupt status set without a rising edge");

endmodule

// ==== source/exit_ctrl.sv ====
// ===============================================
// exit_ctrl: exit value, sticky exit-valid flag
// and a scratch register
// ===============================================
`timescale 1ns/100ps

module exit_ctrl (
  input  logic                clk_gen,
  input  logic                rst_sync_n_i,
  input  board_pkg::slv_req_t req_i,
  output logic [31:0]         rdata_o,
  output logic                hit_o,
  output logic [31:0]         exit_value_o,
  output logic                exit_valid_o
);

  import board_pkg::*;

  localparam logic [3:0] OFF_EXIT    = word_idx(EXIT_ADDR);
  localparam logic [3:0] OFF_SCRATCH = word_idx(SCRATCH_ADDR);

  logic [31:0] exit_value_q;
  logic        exit_valid_q;
  logic [31:0] scratch_q;
  logic        wr_en;

  assign hit_o = req_i.offset inside {OFF_EXIT, OFF_SCRATCH};
  assign wr_en = req_i.sel & req_i.write & hit_o;

  always_ff @(posedge clk_gen or negedge rst_sync_n_i) begin
    if (!rst_sync_n_i) begin
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
      scratch_q    <= '0;
    end else if (wr_en) begin
      if (req_i.offset == OFF_EXIT) begin
        exit_value_q <= req_i.wdata;
        exit_valid_q <= 1'b1;
      end else begin
        scratch_q <= req_i.wdata;
      end
    end
  end

  assign rdata_o      = (req_i.offset == OFF_EXIT) ? exit_value_q :
                        (req_i.offset == OFF_SCRATCH) ? scratch_q : '0;
  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

  exit_valid_sticky_a : assert property (
    @(posedge clk_gen) disable iff (!rst_sync_n_i)
    !$fell(exit_valid_q)
  ) else $error("exit_valid dropped without reset");

endmodule

// ==== source/mini_soc.sv ====
// ===============================================
// mini_soc: register decoder with the GPIO and
// exit controllers behind it
// ===============================================
`timescale 1ns/100ps

module mini_soc #(
  parameter int GPIO_WIDTH = board_pkg::GPIO_WIDTH_DEF
) (
  input  logic                  clk_gen,
  input  logic                  rst_sync_n_i,
  input  board_pkg::reg_req_t   reg_req_i,
  output board_pkg::reg_rsp_t   reg_rsp_o,
  input  logic [GPIO_WIDTH-1:0] gpio_i,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic [GPIO_WIDTH-1:0] gpio_oe_o,
  output logic                  intr_o,
  output logic [31:0]           exit_value_o,
  output logic                  exit_valid_o
);

  import board_pkg::*;

  slv_req_t    gpio_req;
  slv_req_t    exit_req;
  logic [31:0] gpio_rdata;
  logic        gpio_hit;
  logic [31:0] exit_rdata;
  logic        exit_hit;

  reg_decoder reg_decoder_i (
    .clk_gen      (clk_gen),
    .rst_sync_n_i (rst_sync_n_i),
    .reg_req_i    (reg_req_i),
    .reg_rsp_o    (reg_rsp_o),
    .gpio_req_o   (gpio_req),
    .exit_req_o   (exit_req),
    .gpio_rdata_i (gpio_rdata),
    .gpio_hit_i   (gpio_hit),
    .exit_rdata_i (exit_rdata),
    .exit_hit_i   (exit_hit)
  );

  gpio_ctrl #(
    .GPIO_WIDTH (GPIO_WIDTH)
  ) gpio_ctrl_i (
    .clk_gen      (clk_gen),
    .rst_sync_n_i (rst_sync_n_i),
    .req_i        (gpio_req),
    .rdata_o      (gpio_rdata),
    .hit_o        (gpio_hit),
    .gpio_i       (gpio_i),
    .gpio_o       (gpio_o),
    .gpio_oe_o    (gpio_oe_o),
    .intr_o       (intr_o)
  );

  exit_ctrl exit_ctrl_i (
    .clk_gen      (clk_gen),
    .rst_sync_n_i (rst_sync_n_i),
    .req_i        (exit_req),
    .rdata_o      (exit_rdata),
    .hit_o        (exit_hit),
    .exit_value_o (exit_value_o),
    .exit_valid_o (exit_valid_o)
  );

endmodule

// ==== source/board_wrapper.sv ====
// ===============================================
// board_wrapper: top level with board reset, LEDs
// and the register-mapped peripheral subsystem
// ===============================================
`timescale 1ns/100ps

module board_wrapper #(
  parameter int GPIO_WIDTH           = board_pkg::GPIO_WIDTH_DEF,
  parameter int CLK_LED_COUNT_LENGTH = board_pkg::LED_COUNT_DEF
) (
  input  logic                  clk_gen,
  input  logic                  rst_n,
  input  board_pkg::reg_req_t   reg_req_i,
  output board_pkg::reg_rsp_t   reg_rsp_o,
  input  logic [GPIO_WIDTH-1:0] gpio_i,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic [GPIO_WIDTH-1:0] gpio_oe_o,
  output logic                  intr_o,
  output logic [31:0]           exit_value_o,
  output logic                  exit_valid_o,
  output logic                  rst_led_o,
  output logic                  clk_led_o
);

  // synchronized reset for all core logic
  logic rst_sync_n;

  board_status #(
    .CLK_LED_COUNT_LENGTH (CLK_LED_COUNT_LENGTH)
  ) board_status_i (
    .clk_gen      (clk_gen),
    .rst_n        (rst_n),
    .rst_sync_n_o (rst_sync_n),
    .rst_led_o    (rst_led_o),
    .clk_led_o    (clk_led_o)
  );

  mini_soc #(
    .GPIO_WIDTH (GPIO_WIDTH)
  ) mini_soc_i (
    .clk_gen      (clk_gen),
    .rst_sync_n_i (rst_sync_n),
    .reg_req_i    (reg_req_i),
    .reg_rsp_o    (reg_rsp_o),
    .gpio_i       (gpio_i),
    .gpio_o       (gpio_o),
    .gpio_oe_o    (gpio_oe_o),
    .intr_o       (intr_o),
    .exit_value_o (exit_value_o),
    .exit_valid_o (exit_valid_o)
  );

endmodule

// ==== testbench/tb_reg_tasks.svh ====
// ==================================================
// register bus tasks, value check and reference
// model of the register map
// ==================================================

// shadow registers, updated after each write
logic [GW-1:0] sh_out     = '0;
logic [GW-1:0] sh_dir     = '0;
logic [GW-1:0] sh_in      = '0;
logic [GW-1:0] sh_intr    = '0;
logic [GW-1:0] sh_intr_en = '0;
logic [31:0]   sh_exit    = '0;
logic [31:0]   sh_scratch = '0;
logic          sh_valid   = 1'b0;
logic [32:0]   exp_q[$];

task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
  if (got !== exp) begin
    stop_run($sformatf("error at %0d ns: %s is 0x%0h, expected 0x%0h",
                       $time, what, got, exp));
  end
endtask

// expected {error, rdata} of one access
function automatic logic [32:0] ref_read(input logic [7:0] addr, input logic write);
  logic [31:0] data;
  logic        err;
  data = '0;
  err  = 1'b0;
  case (addr)
    GPIO_OUT_ADDR:     data = 32'(sh_out);
    GPIO_DIR_ADDR:     data = 32'(sh_dir);
    GPIO_IN_ADDR:      data = 32'(sh_in);
    GPIO_INTR_ADDR:    data = 32'(sh_intr);
    GPIO_INTR_EN_ADDR: data = 32'(sh_intr_en);
    EXIT_ADDR:         data = sh_exit;
    SCRATCH_ADDR:      data = sh_scratch;
    default:           err  = 1'b1;
  endcase
  return {err, write ? 32'h0 : data};
endfunction

task automatic apply_write(input logic [7:0] addr, input logic [31:0] wdata);
  case (addr)
    GPIO_OUT_ADDR:     sh_out     = wdata[GW-1:0];
    GPIO_DIR_ADDR:     sh_dir     = wdata[GW-1:0];
    GPIO_INTR_ADDR:    sh_intr    = sh_intr & ~wdata[GW-1:0];
    GPIO_INTR_EN_ADDR: sh_intr_en = wdata[GW-1:0];
    EXIT_ADDR: begin
      sh_exit  = wdata;
      sh_valid = 1'b1;
    end
    SCRATCH_ADDR:      sh_scratch = wdata;
    default: ;
  endcase
endtask

task automatic check_pins();
  check_value("gpio_o", 64'(gpio_out), 64'(sh_out));
  check_value("gpio_oe_o", 64'(gpio_oe), 64'(sh_dir));
  check_value("intr_o", 64'(intr), 64'(|(sh_intr & sh_intr_en)));
  check_value("exit_value_o", 64'(exit_value), 64'(sh_exit));
  check_value("exit_valid_o", 64'(exit_valid), 64'(sh_valid));
endtask

// one request cycle, then wait for the response
task automatic issue_request(input logic write, input logic [7:0] addr, input logic [31:0] wdata);
  int cycles;
  exp_q.push_back(ref_read(addr, write));
  @(posedge clk_gen);
  #1;
  reg_req = '{valid: 1'b1, write: write, addr: addr, wdata: wdata};
  @(posedge clk_gen);
  #1;
  reg_req = '0;
  cycles  = 0;
  do begin
    @(negedge clk_gen);
    cycles++;
  end while (reg_rsp.valid !== 1'b1 && cycles < RSP_TIMEOUT);
  if (reg_rsp.valid !== 1'b1) begin
    stop_run("no response from the DUT within the timeout");
  end
  // response belongs in the cycle right after the request
  check_value("response latency in cycles", 64'(cycles), 64'd1);
endtask

task automatic bus_write(input logic [7:0] addr, input logic [31:0] wdata);
  issue_request(1'b1, addr, wdata);
  apply_write(addr, wdata);
  check_pins();
endtask

task automatic bus_read(input logic [7:0] addr);
  issue_request(1'b0, addr, 32'h0);
endtask

task automatic read_all();
  bus_read(GPIO_OUT_ADDR);
  bus_read(GPIO_DIR_ADDR);
  bus_read(GPIO_IN_ADDR);
  bus_read(GPIO_INTR_ADDR);
  bus_read(GPIO_INTR_EN_ADDR);
  bus_read(EXIT_ADDR);
  bus_read(SCRATCH_ADDR);
endtask

// ==== testbench/tb_board_wrapper.sv ====
// ==================================================
// board_wrapper testbench: reset, LEDs, register
// traffic, GPIO edges, unmapped accesses and exit
// ==================================================
`timescale 1ns/100ps

module tb_board_wrapper;

  import board_pkg::*;

  localparam int GW          = 20;
  localparam int LED_LEN     = 4;
  localparam int RSP_TIMEOUT = 8;
  localparam int WAIT_LIMIT  = 64;

  logic          clk_gen;
  logic          rst_n;
  reg_req_t      reg_req;
  reg_rsp_t      reg_rsp;
  logic [GW-1:0] gpio_in;
  logic [GW-1:0] gpio_out;
  logic [GW-1:0] gpio_oe;
  logic          intr;
  logic [31:0]   exit_value;
  logic          exit_valid;
  logic          rst_led;
  logic          clk_led;

  board_wrapper #(
    .GPIO_WIDTH           (GW),
    .CLK_LED_COUNT_LENGTH (LED_LEN)
  ) board_wrapper_i (
    .clk_gen      (clk_gen),
    .rst_n        (rst_n),
    .reg_req_i    (reg_req),
    .reg_rsp_o    (reg_rsp),
    .gpio_i       (gpio_in),
    .gpio_o       (gpio_out),
    .gpio_oe_o    (gpio_oe),
    .intr_o       (intr),
    .exit_value_o (exit_value),
    .exit_valid_o (exit_valid),
    .rst_led_o    (rst_led),
    .clk_led_o    (clk_led)
  );

  always #50 clk_gen = ~clk_gen;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "run stopped");
  endtask

  `include "tb_reg_tasks.svh"

  // every response against the reference model
  always @(negedge clk_gen) begin
    logic [32:0] expected;
    if (reg_rsp.valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        stop_run("a response arrived with no request outstanding");
      end else begin
        expected = exp_q.pop_front();
        check_value("response {error, rdata}",
                    64'({reg_rsp.error, reg_rsp.rdata}), 64'(expected));
      end
    end
  end

  task automatic wait_release();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk_gen);
      cycles++;
    end while (rst_led !== 1'b1 && cycles < WAIT_LIMIT);
    if (rst_led !== 1'b1) begin
      stop_run("reset LED never came on after reset release");
    end
  endtask

  // half period counted from the first rise
  task automatic check_heartbeat();
    int   cycles;
    logic last;
    cycles = 0;
    while (clk_led !== 1'b1 && cycles < WAIT_LIMIT) begin
      @(negedge clk_gen);
      cycles++;
    end
    if (clk_led !== 1'b1) begin
      stop_run("clock LED never rose after reset release");
    end
    for (int i = 0; i < 4; i++) begin
      last   = clk_led;
      cycles = 0;
      do begin
        @(negedge clk_gen);
        cycles++;
      end while (clk_led === last && cycles < WAIT_LIMIT);
      check_value("clk_led_o half period", 64'(cycles), 64'(2 ** (LED_LEN - 1)));
    end
  endtask

  function automatic logic [7:0] pick_rw_addr();
    case ($urandom_range(3, 0))
      0:       return GPIO_OUT_ADDR;
      1:       return GPIO_DIR_ADDR;
      2:       return GPIO_INTR_EN_ADDR;
      default: return SCRATCH_ADDR;
    endcase
  endfunction

  task automatic check_unmapped(input logic [7:0] addr);
    bus_write(addr, $urandom());
    bus_read(addr);
    read_all();
  endtask

  initial begin
    logic [31:0]   rnd;
    logic [GW-1:0] gpio_val;
    void'($urandom(32'h153c));
    clk_gen = 1'b0;
    rst_n   = 1'b0;
    reg_req = '0;
    gpio_in = '0;
    repeat (10) @(posedge clk_gen);
    #1;
    check_value("rst_led_o during reset", 64'(rst_led), 64'd0);
    rst_n = 1'b1;
    wait_release();
    check_value("reg_rsp_o.valid after reset", 64'(reg_rsp.valid), 64'd0);
    check_value("clk_led_o after reset", 64'(clk_led), 64'd0);
    check_pins();
    check_heartbeat();

    for (int i = 0; i < 40; i++) begin
      rnd = $urandom();
      if (rnd[0]) begin
        bus_write(pick_rw_addr(), $urandom());
      end else begin
        bus_read(pick_rw_addr());
      end
    end
    read_all();

    // pins held 4 cycles, edges accumulate in the status
    bus_write(GPIO_INTR_EN_ADDR, $urandom());
    for (int i = 0; i < 12; i++) begin
      rnd      = $urandom();
      gpio_val = rnd[GW-1:0];
      @(posedge clk_gen);
      #1;
      gpio_in = gpio_val;
      repeat (4) @(posedge clk_gen);
      sh_intr = sh_intr | (gpio_val & ~sh_in);
      sh_in   = gpio_val;
      @(negedge clk_gen);
      check_pins();
      bus_read(GPIO_IN_ADDR);
      bus_read(GPIO_INTR_ADDR);
      if (i % 3 == 2) begin
        bus_write(GPIO_INTR_ADDR, $urandom());
        bus_read(GPIO_INTR_ADDR);
      end
    end

    check_unmapped(8'h14);
    check_unmapped(8'h28);
    check_unmapped(8'h40);
    check_unmapped(8'hFC);

    bus_read(EXIT_ADDR);
    bus_write(EXIT_ADDR, $urandom());
    bus_read(EXIT_ADDR);
    bus_write(EXIT_ADDR, $urandom());
    bus_read(EXIT_ADDR);
    read_all();

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+testbench
source/board_pkg.sv
source/board_status.sv
source/reg_decoder.sv
source/gpio_ctrl.sv
source/exit_ctrl.sv
source/mini_soc.sv
source/board_wrapper.sv
testbench/tb_board_wrapper.sv

// ==== Makefile ====
# Verilator build and run for the board wrapper testbench

TOP = tb_board_wrapper

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module $(TOP) -Mdir obj_dir

# the run passes only if the pass message shows up in the output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
